// ==== hw/cw_pkg.sv ====
// Beam codeword stage shared types, bus structs and codeword formula
package cw_pkg;

    localparam int CW_ELEM_W = 8;

    // One antenna coefficient
    typedef logic [CW_ELEM_W-1:0] cw_elem_t;
    // Table entry index
    typedef logic [7:0] cw_idx_t;
    // Symbol phase
    typedef logic [1:0] cw_phase_t;

    typedef struct packed {
        logic      clr;
        logic      first;
        cw_phase_t phase;
    } cw_evt_t;

    // ----------------------------------------
    // Wishbone classic
    // ----------------------------------------
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Even coefficient of entry e, antenna a
    function automatic cw_elem_t cw_even_elem(input int unsigned entry, input int unsigned ant,
                                              input int unsigned ants);
        return cw_elem_t'((entry * ants + ant) % 256);
    endfunction

    // Odd coefficient is the inverse of the even one
    function automatic cw_elem_t cw_odd_elem(input int unsigned entry, input int unsigned ant,
                                             input int unsigned ants);
        return ~cw_even_elem(entry, ant, ants);
    endfunction

endpackage

// ==== hw/cw_rom.sv ====
// Read-only codeword store, even and odd words with two-cycle read latency
`timescale 1ns/1ps

module cw_rom
    import cw_pkg::*;
#(
    parameter int ANTS = 4
) (
    input  logic                      i_clk,
    input  logic                      i_rden,
    input  cw_idx_t                   i_addr,
    output cw_elem_t [ANTS-1:0]       o_even,
    output cw_elem_t [ANTS-1:0]       o_odd
);

    cw_idx_t addr_q;

    // ----------------------------------------
    // Stage 1: address register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rden) begin
            addr_q <= i_addr;
        end
    end

    // ----------------------------------------
    // Stage 2: data register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        for (int a = 0; a < ANTS; a++) begin
            o_even[a] <= cw_even_elem(int'(addr_q), a, ANTS);
            o_odd[a]  <= cw_odd_elem(int'(addr_q), a, ANTS);
        end
    end

endmodule

// ==== hw/cw_table_loader.sv ====
// Table loader, walks every store entry and fills the even and odd tables
`timescale 1ns/1ps

module cw_table_loader
    import cw_pkg::*;
#(
    parameter int BEAMS = 4,
    parameter int ANTS  = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_start,
    input  cw_elem_t [ANTS-1:0]                     i_even,
    input  cw_elem_t [ANTS-1:0]                     i_odd,
    output logic                                    o_rden,
    output cw_idx_t                                 o_addr,
    output logic                                    o_done,
    output cw_elem_t [4*BEAMS-1:0][ANTS-1:0]        o_table_even,
    output cw_elem_t [4*BEAMS-1:0][ANTS-1:0]        o_table_odd
);

    localparam int DEPTH = 4 * BEAMS;
    localparam cw_idx_t LAST = cw_idx_t'(DEPTH - 1);

    logic            active;
    cw_idx_t         cnt;
    logic [1:0]      vld_d;
    cw_idx_t [1:0]   addr_d;

    // ----------------------------------------
    // Address sequencer
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (i_start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST) begin
                active <= 1'b0;
            end
        end
    end

    assign o_rden = active;
    assign o_addr = cnt;

    // Track the address alongside the store's two stages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_d <= '0;
        end else begin
            vld_d <= {vld_d[0], active};
        end
    end

    always_ff @(posedge i_clk) begin
        addr_d[0] <= cnt;
        addr_d[1] <= addr_d[0];
    end

    // ----------------------------------------
    // Table write and completion
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_table_even <= '0;
            o_table_odd  <= '0;
            o_done       <= 1'b0;
        end else begin
            if (vld_d[1]) begin
                o_table_even[addr_d[1]] <= i_even;
                o_table_odd[addr_d[1]]  <= i_odd;
            end
            // Pulses in the cycle following the last table write
            o_done <= vld_d[1] && (addr_d[1] == LAST);
        end
    end

    a_wr_addr_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        vld_d[1] |-> (int'(addr_d[1]) < DEPTH)
    );

endmodule

// ==== hw/cw_beam_select.sv ====
// Beam codeword selector, picks each beam's entry by symbol phase or sorted index
`timescale 1ns/1ps

module cw_beam_select
    import cw_pkg::*;
#(
    parameter int BEAMS = 4,
    parameter int ANTS  = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_evt_valid,
    input  cw_evt_t                                 i_evt,
    input  logic                                    i_rbg_load,
    input  cw_idx_t [BEAMS-1:0]                     i_beam_idx,
    input  cw_elem_t [4*BEAMS-1:0][ANTS-1:0]        i_table_even,
    input  cw_elem_t [4*BEAMS-1:0][ANTS-1:0]        i_table_odd,
    output cw_elem_t [BEAMS-1:0][ANTS-1:0]          o_cw_even,
    output cw_elem_t [BEAMS-1:0][ANTS-1:0]          o_cw_odd,
    output logic                                    o_cw_update
);

    localparam int DEPTH = 4 * BEAMS;

    // Last symbol event had first set and clr clear
    logic                  phase_sel;
    logic                  sym_take;
    logic                  rbg_take;
    cw_idx_t [BEAMS-1:0]   sel_idx;

    assign sym_take = i_evt_valid && (i_evt.clr || i_evt.first);
    assign rbg_take = i_rbg_load && !phase_sel;

    // ----------------------------------------
    // Entry index per beam
    // ----------------------------------------
    always_comb begin
        for (int k = 0; k < BEAMS; k++) begin
            if (i_evt_valid && i_evt.clr) begin
                sel_idx[k] = cw_idx_t'(k);
            end else if (i_evt_valid) begin
                // Phase p uses the p-th block of BEAMS entries
                sel_idx[k] = cw_idx_t'(k + BEAMS * int'(i_evt.phase));
            end else begin
                sel_idx[k] = i_beam_idx[k];
            end
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase_sel   <= 1'b0;
            o_cw_update <= 1'b0;
            o_cw_even   <= '0;
            o_cw_odd    <= '0;
        end else begin
            // Held outputs still count as an update
            o_cw_update <= i_evt_valid || i_rbg_load;
            if (i_evt_valid) begin
                phase_sel <= i_evt.first && !i_evt.clr;
            end
            if (sym_take || rbg_take) begin
                for (int k = 0; k < BEAMS; k++) begin
                    o_cw_even[k] <= i_table_even[sel_idx[k]];
                    o_cw_odd[k]  <= i_table_odd[sel_idx[k]];
                end
            end
        end
    end

    for (genvar k = 0; k < BEAMS; k++) begin : g_idx_chk
        a_sel_range: assert property (
            @(posedge i_clk) disable iff (i_reset)
            (sym_take || rbg_take) |-> (int'(sel_idx[k]) < DEPTH)
        );
    end

endmodule

// ==== hw/cw_ctrl.sv ====
// Control block, Wishbone register slave, load FSM and event pulses
`timescale 1ns/1ps

module cw_ctrl
    import cw_pkg::*;
#(
    parameter int BEAMS = 4
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  wb_req_t               i_wb,
    input  logic                  i_load_done,
    output wb_rsp_t               o_wb,
    output logic                  o_load_start,
    output logic                  o_ready,
    output logic                  o_evt_valid,
    output cw_evt_t               o_evt,
    output logic                  o_rbg_load,
    output cw_idx_t [BEAMS-1:0]   o_beam_idx
);

    localparam int DEPTH  = 4 * BEAMS;
    localparam int BIDX_W = 8 * BEAMS;

    localparam logic [3:0] ADR_CTRL = 4'd0;
    localparam logic [3:0] ADR_SYMB = 4'd1;
    localparam logic [3:0] ADR_BIDX = 4'd2;
    localparam logic [3:0] ADR_RBG  = 4'd3;

    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        READY
    } load_state_t;

    load_state_t           state;
    logic                  ack_q;
    logic [31:0]           rdat_q;
    logic [31:0]           rd_mux;
    logic                  wr_en;
    logic                  start_req;
    cw_idx_t [BEAMS-1:0]   bidx_q;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    // Writes take effect on the acked cycle
    assign wr_en     = i_wb.cyc && i_wb.stb && i_wb.we && ack_q;
    assign start_req = wr_en && (i_wb.adr == ADR_CTRL) && i_wb.dat[0] && (state != LOADING);

    always_comb begin
        case (i_wb.adr)
            ADR_CTRL: rd_mux = {30'd0, state == READY, state == LOADING};
            ADR_BIDX: rd_mux = 32'(bidx_q);
            default:  rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
        end else begin
            // One-cycle ack, then at least one idle cycle
            ack_q <= i_wb.cyc && i_wb.stb && !ack_q;
        end
    end

    always_ff @(posedge i_clk) begin
        rdat_q <= rd_mux;
    end

    assign o_wb = '{ack: ack_q, dat: rdat_q};

    // ----------------------------------------
    // Beam index register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bidx_q <= '0;
        end else if (wr_en && (i_wb.adr == ADR_BIDX)) begin
            bidx_q <= BIDX_W'(i_wb.dat);
        end
    end

    always_comb begin
        for (int k = 0; k < BEAMS; k++) begin
            o_beam_idx[k] = cw_idx_t'(int'(bidx_q[k]) % DEPTH);
        end
    end

    // ----------------------------------------
    // Load FSM
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start_req) state <= LOADING;
                LOADING: if (i_load_done) state <= READY;
                READY:   if (start_req) state <= LOADING;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_ready = (state == READY);

    // Event pulses, dropped unless the tables are loaded
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_load_start <= 1'b0;
            o_evt_valid  <= 1'b0;
            o_rbg_load   <= 1'b0;
        end else begin
            o_load_start <= start_req;
            o_evt_valid  <= wr_en && (i_wb.adr == ADR_SYMB) && (state == READY);
            o_rbg_load   <= wr_en && (i_wb.adr == ADR_RBG) && (state == READY);
        end
    end

    always_ff @(posedge i_clk) begin
        o_evt <= '{clr: i_wb.dat[9], first: i_wb.dat[8], phase: i_wb.dat[1:0]};
    end

    a_ack_single: assert property (
        @(posedge i_clk) disable iff (i_reset)
        ack_q |=> !ack_q
    );

    a_evt_excl: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(o_evt_valid && o_rbg_load)
    );

endmodule

// ==== hw/cw_top.sv ====
// Beam codeword stage top level, control, store, loader and selector
`timescale 1ns/1ps

module cw_top
    import cw_pkg::*;
#(
    parameter int BEAMS = 4,
    parameter int ANTS  = 4
) (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  wb_req_t                           i_wb,
    output wb_rsp_t                           o_wb,
    output cw_elem_t [BEAMS-1:0][ANTS-1:0]    o_cw_even,
    output cw_elem_t [BEAMS-1:0][ANTS-1:0]    o_cw_odd,
    output logic                              o_cw_update,
    output logic                              o_ready
);

    logic                                 load_start;
    logic                                 load_done;
    logic                                 evt_valid;
    cw_evt_t                              evt;
    logic                                 rbg_load;
    cw_idx_t [BEAMS-1:0]                  beam_idx;
    logic                                 rom_rden;
    cw_idx_t                              rom_addr;
    cw_elem_t [ANTS-1:0]                  rom_even;
    cw_elem_t [ANTS-1:0]                  rom_odd;
    cw_elem_t [4*BEAMS-1:0][ANTS-1:0]     table_even;
    cw_elem_t [4*BEAMS-1:0][ANTS-1:0]     table_odd;

    cw_ctrl #(
        .BEAMS (BEAMS)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wb         (i_wb),
        .i_load_done  (load_done),
        .o_wb         (o_wb),
        .o_load_start (load_start),
        .o_ready      (o_ready),
        .o_evt_valid  (evt_valid),
        .o_evt        (evt),
        .o_rbg_load   (rbg_load),
        .o_beam_idx   (beam_idx)
    );

    cw_rom #(
        .ANTS (ANTS)
    ) u_rom (
        .i_clk  (i_clk),
        .i_rden (rom_rden),
        .i_addr (rom_addr),
        .o_even (rom_even),
        .o_odd  (rom_odd)
    );

    cw_table_loader #(
        .BEAMS (BEAMS),
        .ANTS  (ANTS)
    ) u_loader (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_start      (load_start),
        .i_even       (rom_even),
        .i_odd        (rom_odd),
        .o_rden       (rom_rden),
        .o_addr       (rom_addr),
        .o_done       (load_done),
        .o_table_even (table_even),
        .o_table_odd  (table_odd)
    );

    cw_beam_select #(
        .BEAMS (BEAMS),
        .ANTS  (ANTS)
    ) u_select (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_evt_valid  (evt_valid),
        .i_evt        (evt),
        .i_rbg_load   (rbg_load),
        .i_beam_idx   (beam_idx),
        .i_table_even (table_even),
        .i_table_odd  (table_odd),
        .o_cw_even    (o_cw_even),
        .o_cw_odd     (o_cw_odd),
        .o_cw_update  (o_cw_update)
    );

endmodule

// ==== testbench/cw_tb.sv ====
// Testbench for the beam codeword stage with random Wishbone traffic against a reference model
`timescale 1ns/1ps

module cw_tb
    import cw_pkg::*;
;

    localparam int BEAMS          = 4;
    localparam int ANTS           = 4;
    localparam int DEPTH          = 4 * BEAMS;
    localparam int BEAM_W         = ANTS * CW_ELEM_W;
    localparam int N_SYM          = 40;
    localparam int N_MIX          = 80;
    localparam int N_OPS          = N_SYM + N_MIX + 16;
    // Start pulse cycle, then depth plus 3 until ready
    localparam int LOAD_CYCLES    = DEPTH + 4;
    localparam int WAIT_LIMIT     = 20;
    localparam int TIMEOUT_CYCLES = N_OPS * 20 + LOAD_CYCLES * 4;

    localparam logic [3:0] ADR_CTRL = 4'd0;
    localparam logic [3:0] ADR_SYMB = 4'd1;
    localparam logic [3:0] ADR_BIDX = 4'd2;
    localparam logic [3:0] ADR_RBG  = 4'd3;

    logic                            i_clk;
    logic                            i_reset;
    wb_req_t                         wb_req;
    wb_rsp_t                         wb_rsp;
    cw_elem_t [BEAMS-1:0][ANTS-1:0]  cw_even;
    cw_elem_t [BEAMS-1:0][ANTS-1:0]  cw_odd;
    logic                            cw_update;
    logic                            ready;

    // Reference model state
    logic [BEAM_W-1:0]  tab_even [DEPTH];
    logic [BEAM_W-1:0]  tab_odd [DEPTH];
    logic [BEAM_W-1:0]  exp_even [BEAMS];
    logic [BEAM_W-1:0]  exp_odd [BEAMS];
    logic               phase_sel;
    logic [31:0]        bidx_reg;
    integer             seed;

    cw_top #(
        .BEAMS (BEAMS),
        .ANTS  (ANTS)
    ) i_dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .o_cw_even   (cw_even),
        .o_cw_odd    (cw_odd),
        .o_cw_update (cw_update),
        .o_ready     (ready)
    );

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic stop_run(input string reason);
        $display("STATUS: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual 0x%08h expected 0x%08h", name, actual, expected);
            stop_run("a DUT output did not match the reference model");
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic build_tables();
        for (int e = 0; e < DEPTH; e++) begin
            for (int a = 0; a < ANTS; a++) begin
                tab_even[e][a*CW_ELEM_W +: CW_ELEM_W] = cw_even_elem(e, a, ANTS);
                tab_odd[e][a*CW_ELEM_W +: CW_ELEM_W]  = cw_odd_elem(e, a, ANTS);
            end
        end
        for (int k = 0; k < BEAMS; k++) begin
            exp_even[k] = '0;
            exp_odd[k]  = '0;
        end
        phase_sel = 1'b0;
        bidx_reg  = '0;
    endtask

    task automatic symbol_rule(input logic clr, input logic first, input logic [1:0] phase);
        int entry;
        for (int k = 0; k < BEAMS; k++) begin
            entry = clr ? k : k + BEAMS * int'(phase);
            if (clr || first) begin
                exp_even[k] = tab_even[entry];
                exp_odd[k]  = tab_odd[entry];
            end
        end
        phase_sel = first && !clr;
    endtask

    task automatic rbg_rule();
        int entry;
        // Sorted indices are ignored while phase selection is active
        if (!phase_sel) begin
            for (int k = 0; k < BEAMS; k++) begin
                entry       = int'(bidx_reg[8*k +: 8]) % DEPTH;
                exp_even[k] = tab_even[entry];
                exp_odd[k]  = tab_odd[entry];
            end
        end
    endtask

    // ----------------------------------------
    // Bus and timing helpers
    // ----------------------------------------
    task automatic step();
        @(posedge i_clk);
        #2;
    endtask

    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        waited     = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        step();
        while (!wb_rsp.ack) begin
            step();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("Wishbone ack never arrived");
            end
        end
        rdat = wb_rsp.dat;
        // Master sees ack at the next edge and ends the cycle there
        step();
        check("o_wb.ack", wb_rsp.ack, 1'b0);
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, '0, rdat);
    endtask

    task automatic compare_outputs();
        for (int k = 0; k < BEAMS; k++) begin
            check($sformatf("o_cw_even[%0d]", k), cw_even[k], exp_even[k]);
            check($sformatf("o_cw_odd[%0d]", k), cw_odd[k], exp_odd[k]);
        end
    endtask

    task automatic wait_update();
        int waited;
        waited = 0;
        while (!cw_update) begin
            step();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("o_cw_update never pulsed after an event");
            end
        end
        compare_outputs();
        step();
        check("o_cw_update", cw_update, 1'b0);
    endtask

    task automatic wait_ready(output int cycles);
        cycles = 0;
        while (!ready) begin
            step();
            cycles++;
            if (cycles > LOAD_CYCLES + WAIT_LIMIT) begin
                stop_run("o_ready never rose after a load start");
            end
        end
    endtask

    task automatic symbol_event(input logic clr, input logic first, input logic [1:0] phase);
        logic [31:0] wdat;
        wdat      = '0;
        wdat[1:0] = phase;
        wdat[8]   = first;
        wdat[9]   = clr;
        wb_write(ADR_SYMB, wdat);
        symbol_rule(clr, first, phase);
        wait_update();
    endtask

    task automatic random_symbol();
        logic [31:0] rnd;
        rnd = $random(seed);
        symbol_event(rnd[5:4] == 2'b00, rnd[8], rnd[1:0]);
    endtask

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge i_clk);
        stop_run("Watchdog expired before the tests finished");
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rdat;
        logic [31:0] rnd;
        int          cycles;

        seed    = 32'h4a48_5db2;
        i_reset = 1'b1;
        wb_req  = '0;
        build_tables();
        repeat (8) @(posedge i_clk);
        #2;
        i_reset = 1'b0;

        // Reset values
        check("o_wb.ack", wb_rsp.ack, 1'b0);
        check("o_ready", ready, 1'b0);
        check("o_cw_update", cw_update, 1'b0);
        compare_outputs();
        wb_read(ADR_CTRL, rdat);
        check("CTRL", rdat, 32'h0);

        // Events before a load are dropped
        wb_write(ADR_SYMB, 32'h0000_0101);
        repeat (10) begin
            step();
            check("o_cw_update", cw_update, 1'b0);
        end

        // First load
        wb_write(ADR_CTRL, 32'h1);
        wait_ready(cycles);
        check("load cycles", cycles, LOAD_CYCLES);
        wb_read(ADR_CTRL, rdat);
        check("CTRL", rdat, 32'h2);

        // Random symbol events
        for (int n = 0; n < N_SYM; n++) begin
            random_symbol();
        end

        // Beam index readback
        rnd = $random(seed);
        wb_write(ADR_BIDX, rnd);
        bidx_reg = rnd;
        wb_read(ADR_BIDX, rdat);
        check("BIDX", rdat, bidx_reg);

        // Mixed index, RBG and symbol traffic
        for (int n = 0; n < N_MIX; n++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0: begin
                    rnd = $random(seed);
                    wb_write(ADR_BIDX, rnd);
                    bidx_reg = rnd;
                end
                2'd1: begin
                    wb_write(ADR_RBG, $random(seed));
                    rbg_rule();
                    wait_update();
                end
                default: random_symbol();
            endcase
        end

        // Reload from READY
        wb_write(ADR_CTRL, 32'h1);
        check("o_ready", ready, 1'b0);
        wait_ready(cycles);
        check("load cycles", cycles, LOAD_CYCLES);
        wb_read(ADR_CTRL, rdat);
        check("CTRL", rdat, 32'h2);
        rnd = $random(seed);
        symbol_event(1'b1, rnd[0], rnd[2:1]);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
hw/cw_pkg.sv
hw/cw_rom.sv
hw/cw_table_loader.sv
hw/cw_beam_select.sv
hw/cw_ctrl.sv
hw/cw_top.sv
testbench/cw_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cw_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
